// ==== verilog/vdp_cmd_pkg.sv ====
`default_nettype none

package vdp_cmd_pkg;

  // Coordinate and address widths
  localparam int unsigned X_W    = 9;
  localparam int unsigned Y_W    = 10;
  localparam int unsigned ADDR_W = 17;

  // Register numbers, offset from R32
  localparam logic [3:0] REG_SX_L = 4'h0;
  localparam logic [3:0] REG_SX_H = 4'h1;
  localparam logic [3:0] REG_SY_L = 4'h2;
  localparam logic [3:0] REG_SY_H = 4'h3;
  localparam logic [3:0] REG_DX_L = 4'h4;
  localparam logic [3:0] REG_DX_H = 4'h5;
  localparam logic [3:0] REG_DY_L = 4'h6;
  localparam logic [3:0] REG_DY_H = 4'h7;
  localparam logic [3:0] REG_NX_L = 4'h8;
  localparam logic [3:0] REG_NX_H = 4'h9;
  localparam logic [3:0] REG_NY_L = 4'ha;
  localparam logic [3:0] REG_NY_H = 4'hb;
  // R44, color
  localparam logic [3:0] REG_CLR  = 4'hc;
  // R45, direction bits
  localparam logic [3:0] REG_ARG  = 4'hd;
  // R46, command and logical operation
  localparam logic [3:0] REG_CMD  = 4'he;

  // Command codes, upper nibble of R46
  localparam logic [3:0] CMD_STOP  = 4'b0000;
  localparam logic [3:0] CMD_POINT = 4'b0100;
  localparam logic [3:0] CMD_PSET  = 4'b0101;
  localparam logic [3:0] CMD_LMMV  = 4'b1000;
  localparam logic [3:0] CMD_HMMV  = 4'b1100;

  // Logical operations, R46 bits 2..0
  // Bit 3 of R46 is the transparent flag
  localparam logic [2:0] LOP_IMP = 3'b000;
  localparam logic [2:0] LOP_AND = 3'b001;
  localparam logic [2:0] LOP_OR  = 3'b010;
  localparam logic [2:0] LOP_XOR = 3'b011;
  localparam logic [2:0] LOP_NOT = 3'b100;

  // One VRAM byte
  // Graphic 7 reads it whole, graphic 4 as two dots
  // Even dot lives in the high nibble
  typedef union packed {
    logic [7:0] whole;
    struct packed {
      logic [3:0] hi;
      logic [3:0] lo;
    } nib;
  } vram_byte_u;

endpackage

`default_nettype wire

// ==== verilog/vdp_cmd_pixel_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_pixel_unit
  import vdp_cmd_pkg::*;
(
  input  wire  [7:0] rd_byte,
  input  wire        x_low,
  input  wire  [7:0] clr,
  input  wire  [3:0] lop,
  input  wire        mode_graphic_7,
  output logic [7:0] merged_byte,
  output logic [7:0] point
);

  vram_byte_u rd_u;
  vram_byte_u mrg_u;
  logic [7:0] col_mask;
  logic [7:0] src_col;
  logic [7:0] dst_dot;
  logic [7:0] lop_res;

  // Dot width of the mode
  assign col_mask = mode_graphic_7 ? 8'hff : 8'h0f;
  assign src_col  = clr & col_mask;

  // Pick the addressed dot out of the byte
  always_comb begin
    rd_u = rd_byte;
    if (mode_graphic_7) begin
      dst_dot = rd_u.whole;
    end else if (x_low) begin
      // Odd X, low nibble
      dst_dot = {4'h0, rd_u.nib.lo};
    end else begin
      dst_dot = {4'h0, rd_u.nib.hi};
    end
  end

  // Logical operation between color and old dot
  always_comb begin
    if (lop[3] && (src_col == 8'h00)) begin
      // Transparent, zero color keeps destination
      lop_res = dst_dot;
    end else begin
      case (lop[2:0])
        LOP_IMP: lop_res = src_col;
        LOP_AND: lop_res = src_col & dst_dot;
        LOP_OR:  lop_res = src_col | dst_dot;
        LOP_XOR: lop_res = src_col ^ dst_dot;
        // Inverted color, trimmed to the dot
        LOP_NOT: lop_res = ~src_col & col_mask;
        default: lop_res = dst_dot;
      endcase
    end
  end

  // Put the new dot back next to its neighbour
  always_comb begin
    mrg_u = rd_u;
    if (mode_graphic_7) begin
      mrg_u.whole = lop_res;
    end else if (x_low) begin
      mrg_u.nib.lo = lop_res[3:0];
    end else begin
      mrg_u.nib.hi = lop_res[3:0];
    end
  end

  assign merged_byte = mrg_u.whole;
  // POINT result is the untouched dot
  assign point       = dst_dot;

endmodule

`default_nettype wire

// ==== verilog/vdp_cmd_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_regs
  import vdp_cmd_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              reg_wr_req,
  input  wire  [3:0]       reg_num,
  input  wire  [7:0]       reg_data,
  input  wire              point_load,
  input  wire  [7:0]       point_data,
  input  wire              ce,
  input  wire              mode_graphic_7,
  output logic             reg_wr_ack,
  output logic             busy,
  output logic             start,
  output logic [X_W-1:0]   sx,
  output logic [Y_W-1:0]   sy,
  output logic [X_W-1:0]   dx,
  output logic [Y_W-1:0]   dy,
  output logic [Y_W-1:0]   nx,
  output logic [Y_W-1:0]   ny,
  output logic             dix,
  output logic             diy,
  output logic [3:0]       cmd,
  output logic [3:0]       lop,
  output logic [7:0]       clr
);

  // Color written while a dot command runs in graphic 4
  logic clr_nibble;

  // Request differs from ack, one write pending
  assign busy = (reg_wr_req != reg_wr_ack);

  assign clr_nibble = ce && (cmd != CMD_HMMV) && !mode_graphic_7;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      start      <= 1'b0;
      sx         <= '0;
      sy         <= '0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmd        <= CMD_STOP;
      lop        <= '0;
      clr        <= '0;
    end else begin
      start <= 1'b0;
      // POINT result; a CPU color write below overrides it
      if (point_load) begin
        clr <= point_data;
      end
      if (busy) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_SX_L: sx[7:0] <= reg_data;
          REG_SX_H: sx[X_W-1] <= reg_data[0];
          REG_SY_L: sy[7:0] <= reg_data;
          REG_SY_H: sy[Y_W-1:8] <= reg_data[1:0];
          REG_DX_L: dx[7:0] <= reg_data;
          REG_DX_H: dx[X_W-1] <= reg_data[0];
          REG_DY_L: dy[7:0] <= reg_data;
          REG_DY_H: dy[Y_W-1:8] <= reg_data[1:0];
          REG_NX_L: nx[7:0] <= reg_data;
          REG_NX_H: nx[Y_W-1:8] <= reg_data[1:0];
          REG_NY_L: ny[7:0] <= reg_data;
          REG_NY_H: ny[Y_W-1:8] <= reg_data[1:0];
          REG_CLR: begin
            // Dot commands only see one nibble in graphic 4
            clr <= clr_nibble ? {4'h0, reg_data[3:0]} : reg_data;
          end
          REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          REG_CMD: begin
            // New command, aborts whatever is running
            cmd   <= reg_data[7:4];
            lop   <= reg_data[3:0];
            start <= 1'b1;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_cmd_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_sequencer
  import vdp_cmd_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               busy,
  input  wire               start,
  input  wire  [X_W-1:0]    sx,
  input  wire  [Y_W-1:0]    sy,
  input  wire  [X_W-1:0]    dx,
  input  wire  [Y_W-1:0]    dy,
  input  wire  [Y_W-1:0]    nx,
  input  wire  [Y_W-1:0]    ny,
  input  wire               dix,
  input  wire               diy,
  input  wire  [3:0]        cmd,
  input  wire  [7:0]        clr,
  input  wire               mode_graphic_7,
  input  wire               vram_rd_ack,
  input  wire               vram_wr_ack,
  input  wire  [7:0]        vram_rd_data,
  input  wire  [7:0]        merged_byte,
  input  wire  [7:0]        point,
  output logic              ce,
  output logic              point_load,
  output logic [7:0]        point_data,
  output logic              vram_rd_req,
  output logic              vram_wr_req,
  output logic [ADDR_W-1:0] vram_addr,
  output logic [7:0]        vram_wr_data,
  output logic [7:0]        rd_byte,
  output logic              x_low
);

  localparam logic [3:0] ST_IDLE        = 4'd0;
  localparam logic [3:0] ST_CHK_LOOP    = 4'd1;
  localparam logic [3:0] ST_PRE_RD      = 4'd2;
  localparam logic [3:0] ST_WAIT_PRE_RD = 4'd3;
  localparam logic [3:0] ST_WR          = 4'd4;
  localparam logic [3:0] ST_WAIT_WR     = 4'd5;
  localparam logic [3:0] ST_RD_POINT    = 4'd6;
  localparam logic [3:0] ST_WAIT_POINT  = 4'd7;
  localparam logic [3:0] ST_END         = 4'd8;

  logic [3:0]        state;
  // Top X bit catches both 256 and the wrap below zero
  logic [X_W-1:0]    x_cur;
  logic [X_W-1:0]    x_next;
  logic [Y_W-1:0]    y_cur;
  logic [Y_W-1:0]    y_next;
  logic [Y_W-1:0]    nx_cnt;
  logic [Y_W-1:0]    ny_cnt;
  logic [Y_W-1:0]    nx_load;
  logic              init;
  logic              byte_pair;
  logic              nx_end;
  logic              ny_end;
  logic              bus_idle;
  logic              advance;
  logic [ADDR_W-1:0] dst_addr;
  logic [ADDR_W-1:0] pnt_addr;

  // Byte address of a dot in the current mode
  function automatic logic [ADDR_W-1:0] map_addr(input logic [X_W-1:0] x,
                                                 input logic [Y_W-1:0] y,
                                                 input logic g7);
    if (g7) begin
      return {y[8:0], x[7:0]};
    end
    return {y, x[7:1]};
  endfunction

  // HMMV in graphic 4 moves a byte, i.e. two dots, per step
  assign byte_pair = (cmd == CMD_HMMV) && !mode_graphic_7;
  assign nx_load   = byte_pair ? {1'b0, nx[Y_W-1:1]} : nx;
  assign x_next    = dix ? x_cur - (byte_pair ? X_W'(2) : X_W'(1))
                         : x_cur + (byte_pair ? X_W'(2) : X_W'(1));
  assign y_next    = diy ? y_cur - Y_W'(1) : y_cur + Y_W'(1);

  // Row and rectangle end conditions
  assign nx_end = (nx_cnt == '0) || x_cur[X_W-1];
  assign ny_end = (ny_cnt == Y_W'(1)) || (diy && (y_cur == '0));

  assign dst_addr = map_addr(x_cur, y_cur, mode_graphic_7);
  assign pnt_addr = map_addr(sx, sy, mode_graphic_7);

  // Never two VRAM requests outstanding
  assign bus_idle = (vram_rd_req == vram_rd_ack) && (vram_wr_req == vram_wr_ack);
  // Register writes freeze the walk
  assign advance  = !start && !busy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= ST_IDLE;
      ce          <= 1'b0;
      point_load  <= 1'b0;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
      init        <= 1'b0;
      x_cur       <= '0;
      y_cur       <= '0;
      nx_cnt      <= '0;
      ny_cnt      <= '0;
    end else begin
      point_load <= 1'b0;
      if (start) begin
        // Fresh command, restart from DX/DY
        state  <= ST_CHK_LOOP;
        ce     <= 1'b1;
        init   <= 1'b1;
        x_cur  <= dx;
        y_cur  <= dy;
        nx_cnt <= nx_load;
        ny_cnt <= ny;
      end else if (advance) begin
        case (state)
          ST_IDLE: ce <= 1'b0;
          ST_CHK_LOOP: begin
            init <= 1'b0;
            if (!init && nx_end && ny_end) begin
              state <= ST_END;
            end else begin
              case (cmd)
                CMD_HMMV: state <= ST_WR;
                CMD_LMMV, CMD_PSET: state <= ST_PRE_RD;
                CMD_POINT: state <= ST_RD_POINT;
                CMD_STOP: state <= ST_END;
                default: state <= ST_END;
              endcase
            end
            // Next row
            if (!init && nx_end) begin
              x_cur  <= dx;
              nx_cnt <= nx_load;
              ny_cnt <= ny_cnt - Y_W'(1);
              y_cur  <= y_next;
            end
          end
          ST_PRE_RD: begin
            if (bus_idle) begin
              vram_rd_req <= ~vram_rd_req;
              state       <= ST_WAIT_PRE_RD;
            end
          end
          ST_WAIT_PRE_RD: begin
            if (vram_rd_req == vram_rd_ack) begin
              state <= ST_WR;
            end
          end
          ST_WR: begin
            if (bus_idle) begin
              vram_wr_req <= ~vram_wr_req;
              state       <= ST_WAIT_WR;
            end
          end
          ST_WAIT_WR: begin
            if (vram_wr_req == vram_wr_ack) begin
              if (cmd == CMD_PSET) begin
                state <= ST_END;
              end else begin
                x_cur  <= x_next;
                nx_cnt <= nx_cnt - Y_W'(1);
                state  <= ST_CHK_LOOP;
              end
            end
          end
          ST_RD_POINT: begin
            if (bus_idle) begin
              vram_rd_req <= ~vram_rd_req;
              state       <= ST_WAIT_POINT;
            end
          end
          ST_WAIT_POINT: begin
            if (vram_rd_req == vram_rd_ack) begin
              state <= ST_END;
            end
          end
          ST_END: begin
            // clr picks up the dot as ce drops
            point_load <= (cmd == CMD_POINT);
            state      <= ST_IDLE;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // Address, data and read byte follow the same steps
  always_ff @(posedge clk) begin
    if (advance) begin
      case (state)
        ST_PRE_RD: begin
          if (bus_idle) begin
            vram_addr <= dst_addr;
            x_low     <= x_cur[0];
          end
        end
        ST_WAIT_PRE_RD, ST_WAIT_POINT: begin
          if (vram_rd_req == vram_rd_ack) begin
            rd_byte <= vram_rd_data;
          end
        end
        ST_WR: begin
          if (bus_idle) begin
            vram_addr    <= dst_addr;
            vram_wr_data <= (cmd == CMD_HMMV) ? clr : merged_byte;
          end
        end
        ST_RD_POINT: begin
          if (bus_idle) begin
            vram_addr <= pnt_addr;
            x_low     <= sx[0];
          end
        end
        ST_END: point_data <= point;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_cmd_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_engine
  import vdp_cmd_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  // CPU register port, toggle handshake
  input  wire               reg_wr_req,
  input  wire  [3:0]        reg_num,
  input  wire  [7:0]        reg_data,
  output logic              reg_wr_ack,
  // High for graphic 7, low for graphic 4
  input  wire               mode_graphic_7,
  // VRAM port, separate read and write toggles
  output logic              vram_rd_req,
  input  wire               vram_rd_ack,
  input  wire  [7:0]        vram_rd_data,
  output logic              vram_wr_req,
  input  wire               vram_wr_ack,
  output logic [ADDR_W-1:0] vram_addr,
  output logic [7:0]        vram_wr_data,
  // Status
  output logic [7:0]        clr,
  output logic              ce,
  output logic [3:0]        cur_cmd
);

  logic           busy;
  logic           start;
  logic [X_W-1:0] sx;
  logic [Y_W-1:0] sy;
  logic [X_W-1:0] dx;
  logic [Y_W-1:0] dy;
  logic [Y_W-1:0] nx;
  logic [Y_W-1:0] ny;
  logic           dix;
  logic           diy;
  logic [3:0]     lop;
  logic           point_load;
  logic [7:0]     point_data;
  logic [7:0]     rd_byte;
  logic           x_low;
  logic [7:0]     merged_byte;
  logic [7:0]     point;

  // Register stage, command nibble doubles as status
  vdp_cmd_regs u_regs (.cmd(cur_cmd), .*);

  // Walks the rectangle and runs the VRAM handshakes
  vdp_cmd_sequencer u_seq (.cmd(cur_cmd), .*);

  // Read-modify-write data path
  vdp_cmd_pixel_unit u_pix (.*);

endmodule

`default_nettype wire

// ==== sim/vdp_cmd_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_props
  import vdp_cmd_pkg::*;
(
  input wire              clk,
  input wire              reset,
  input wire              vram_rd_req,
  input wire              vram_rd_ack,
  input wire              vram_wr_req,
  input wire              vram_wr_ack,
  input wire [ADDR_W-1:0] vram_addr,
  input wire              ce
);

  // Count of failed assertions
  int unsigned fail_count = 0;
  logic        rd_pend;
  logic        wr_pend;

  assign rd_pend = (vram_rd_req != vram_rd_ack);
  assign wr_pend = (vram_wr_req != vram_wr_ack);

  // Address held until the ack matches the request
  addr_held: assert property (@(posedge clk) disable iff (reset)
    (rd_pend || wr_pend) |=> (!(rd_pend || wr_pend) || $stable(vram_addr)))
    else begin
      $error("vram_addr moved while an access was pending");
      fail_count++;
    end

  // One VRAM access at a time
  one_access: assert property (@(posedge clk) disable iff (reset)
    !(rd_pend && wr_pend))
    else begin
      $error("read and write pending together");
      fail_count++;
    end

  ce_after_reset: assert property (@(posedge clk) $past(reset) |-> !ce)
    else begin
      $error("ce high right after reset");
      fail_count++;
    end

endmodule

bind vdp_cmd_engine vdp_cmd_props props (
  .clk         (clk),
  .reset       (reset),
  .vram_rd_req (vram_rd_req),
  .vram_rd_ack (vram_rd_ack),
  .vram_wr_req (vram_wr_req),
  .vram_wr_ack (vram_wr_ack),
  .vram_addr   (vram_addr),
  .ce          (ce)
);

`default_nettype wire

// ==== sim/vdp_cmd_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vdp_cmd_tb
  import vdp_cmd_pkg::*;
();

  logic              clk;
  logic              reset;
  logic              reg_wr_req;
  logic [3:0]        reg_num;
  logic [7:0]        reg_data;
  logic              reg_wr_ack;
  logic              mode_graphic_7;
  logic              vram_rd_req;
  logic              vram_rd_ack;
  logic [7:0]        vram_rd_data;
  logic              vram_wr_req;
  logic              vram_wr_ack;
  logic [ADDR_W-1:0] vram_addr;
  logic [7:0]        vram_wr_data;
  logic [7:0]        clr;
  logic              ce;
  logic [3:0]        cur_cmd;

  // VRAM contents and the contents the tests expect
  vram_byte_u        vram [0:(1 << ADDR_W)-1];
  vram_byte_u        ref_mem [0:(1 << ADDR_W)-1];
  logic [16:0]       lfsr;
  logic [2:0]        rd_cnt;
  logic [2:0]        wr_cnt;
  logic [2:0]        delay;

  vdp_cmd_engine dut (.*);

  always #20 clk = ~clk;

  // 17-bit Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // Ack latency of 1 to 4 cycles, one LFSR step per bit
  task automatic pick_delay(output logic [2:0] d);
    logic [1:0] bits;
    lfsr = lfsr_step(lfsr);
    bits[0] = lfsr[0];
    lfsr = lfsr_step(lfsr);
    bits[1] = lfsr[0];
    d = {1'b0, bits} + 3'd1;
  endtask

  // VRAM model, answers each toggle after a random delay
  always @(posedge clk) begin
    if (rd_cnt != 3'd0) begin
      if (rd_cnt == 3'd1) begin
        vram_rd_data <= vram[vram_addr];
        vram_rd_ack  <= ~vram_rd_ack;
      end
      rd_cnt <= rd_cnt - 3'd1;
    end else if (vram_rd_req != vram_rd_ack) begin
      pick_delay(delay);
      rd_cnt <= delay;
    end
    if (wr_cnt != 3'd0) begin
      if (wr_cnt == 3'd1) begin
        vram[vram_addr] <= vram_wr_data;
        vram_wr_ack     <= ~vram_wr_ack;
      end
      wr_cnt <= wr_cnt - 3'd1;
    end else if (vram_wr_req != vram_wr_ack) begin
      pick_delay(delay);
      wr_cnt <= delay;
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic wait_expired(input string what);
    $display("Timed out waiting for %s", what);
    abort_run();
  endtask

  // Stop at the first failed handshake assertion
  always @(negedge clk) begin
    if (dut.props.fail_count != 0) begin
      $display("A handshake assertion in the bound checker failed");
      abort_run();
    end
  end

  task automatic check_byte(input string name, input vram_byte_u expected,
                            input vram_byte_u actual);
    if (expected.whole !== actual.whole) begin
      $display("MISMATCH %s expected %02h actual %02h", name, expected.whole,
               actual.whole);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %0b actual %0b", name, expected, actual);
      abort_run();
    end
  endtask

  // Dot after the logical operation, per the R46 rules
  function automatic logic [7:0] expected_dot(input logic [7:0] dst, input logic [7:0] color,
                                              input logic [3:0] op, input logic g7);
    logic [7:0] mask;
    logic [7:0] src;
    mask = g7 ? 8'hff : 8'h0f;
    src  = color & mask;
    if (op[3] && (src == 8'h00)) begin
      return dst;
    end
    case (op[2:0])
      LOP_IMP: return src;
      LOP_AND: return src & dst;
      LOP_OR:  return src | dst;
      LOP_XOR: return src ^ dst;
      LOP_NOT: return ~src & mask;
      default: return dst;
    endcase
  endfunction

  // Fill pattern, every address bit takes part
  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    return a[7:0] ^ {a[14:8], a[16]} ^ {a[15], 7'h2b};
  endfunction

  task automatic fill_memory();
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      vram[a]    = fill_byte(17'(a));
      ref_mem[a] = fill_byte(17'(a));
    end
  endtask

  task automatic compare_all(input string name);
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      if (vram[a] !== ref_mem[a]) begin
        check_byte($sformatf("%s addr %05h", name, a), ref_mem[a], vram[a]);
      end
    end
  endtask

  task automatic set_mode(input logic g7);
    @(posedge clk);
    mode_graphic_7 <= g7;
  endtask

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    int waited;
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    waited = 0;
    @(negedge clk);
    while (reg_wr_ack != reg_wr_req) begin
      @(negedge clk);
      waited++;
      if (waited > 8) begin
        wait_expired("the register write acknowledge");
      end
    end
  endtask

  task automatic set_rect(input logic [8:0] x, input logic [9:0] y, input logic [9:0] nx,
                          input logic [9:0] ny, input logic [7:0] arg);
    write_reg(REG_DX_L, x[7:0]);
    write_reg(REG_DX_H, {7'h0, x[8]});
    write_reg(REG_DY_L, y[7:0]);
    write_reg(REG_DY_H, {6'h0, y[9:8]});
    write_reg(REG_NX_L, nx[7:0]);
    write_reg(REG_NX_H, {6'h0, nx[9:8]});
    write_reg(REG_NY_L, ny[7:0]);
    write_reg(REG_NY_H, {6'h0, ny[9:8]});
    write_reg(REG_ARG, arg);
  endtask

  task automatic set_point(input logic [8:0] x, input logic [9:0] y);
    write_reg(REG_SX_L, x[7:0]);
    write_reg(REG_SX_H, {7'h0, x[8]});
    write_reg(REG_SY_L, y[7:0]);
    write_reg(REG_SY_H, {6'h0, y[9:8]});
  endtask

  // Command write, then ce high and back low
  task automatic run_command(input logic [7:0] cmd_byte);
    int waited;
    write_reg(REG_CMD, cmd_byte);
    waited = 0;
    while (!ce) begin
      @(negedge clk);
      waited++;
      if (waited > 2) begin
        wait_expired("ce to rise after the command write");
      end
    end
    waited = 0;
    while (ce) begin
      @(negedge clk);
      waited++;
      if (waited > 5000) begin
        wait_expired("the command to finish");
      end
    end
  endtask

  task automatic test_registers();
    logic exp_ack;
    check_flag("reset reg_wr_ack", 1'b0, reg_wr_ack);
    check_flag("reset vram_rd_req", 1'b0, vram_rd_req);
    check_flag("reset vram_wr_req", 1'b0, vram_wr_req);
    check_flag("reset ce", 1'b0, ce);
    check_byte("reset clr", 8'h00, clr);
    exp_ack = 1'b0;
    for (int i = 0; i < 14; i++) begin
      @(posedge clk);
      reg_num    <= 4'(i);
      reg_data   <= 8'(8'h11 * (i + 1));
      reg_wr_req <= ~reg_wr_req;
      @(negedge clk);
      check_flag($sformatf("reg %0d ack before", i), exp_ack, reg_wr_ack);
      exp_ack = ~exp_ack;
      @(negedge clk);
      check_flag($sformatf("reg %0d ack toggled", i), exp_ack, reg_wr_ack);
      @(negedge clk);
      check_flag($sformatf("reg %0d ack once", i), exp_ack, reg_wr_ack);
    end
    // R44 written 0xdd with no command running
    check_byte("clr register", 8'hdd, clr);
    // Dropped command code, still shown on cur_cmd
    run_command(8'ha5);
    check_byte("cur_cmd", 8'h0a, {4'h0, cur_cmd});
  endtask

  task automatic test_pset_g7();
    logic [8:0]  x;
    logic [9:0]  y;
    logic [7:0]  color;
    logic [3:0]  op;
    logic [16:0] a;
    set_mode(1'b1);
    fill_memory();
    for (int t = 0; t < 2; t++) begin
      for (int k = 0; k < 5; k++) begin
        for (int z = 0; z < 2; z++) begin
          x     = 9'(30 + 10 * k + 3 * z + t);
          y     = 10'(50 + 7 * t + z);
          color = (z == 1) ? 8'h00 : 8'hc6;
          op    = {1'(t), 3'(k)};
          set_rect(x, y, 10'd1, 10'd1, 8'h00);
          write_reg(REG_CLR, color);
          run_command({CMD_PSET, op});
          a = {y[8:0], x[7:0]};
          ref_mem[a] = expected_dot(ref_mem[a], color, op, 1'b1);
          check_byte($sformatf("pset lop %0d transp %0d color %02h", k, t, color),
                     ref_mem[a], vram[a]);
        end
      end
    end
  endtask

  // Update the expected nibbles of an LMMV rectangle
  task automatic model_lmmv(input logic [8:0] x0, input logic [9:0] y0, input int nx,
                            input int ny, input logic [7:0] color, input logic [3:0] op);
    logic [8:0]  x;
    logic [9:0]  y;
    logic [16:0] a;
    logic [7:0]  dot;
    vram_byte_u  b;
    for (int r = 0; r < ny; r++) begin
      for (int c = 0; c < nx; c++) begin
        // DIX and DIY set, both walks go down
        x = x0 - 9'(c);
        y = y0 - 10'(r);
        a = {y, x[7:1]};
        b = ref_mem[a];
        if (x[0]) begin
          dot      = expected_dot({4'h0, b.nib.lo}, color, op, 1'b0);
          b.nib.lo = dot[3:0];
        end else begin
          dot      = expected_dot({4'h0, b.nib.hi}, color, op, 1'b0);
          b.nib.hi = dot[3:0];
        end
        ref_mem[a] = b;
      end
    end
  endtask

  task automatic test_lmmv_g4();
    set_mode(1'b0);
    fill_memory();
    set_rect(9'd101, 10'd300, 10'd4, 10'd3, 8'h0c);
    write_reg(REG_CLR, 8'ha6);
    run_command({CMD_LMMV, 1'b0, LOP_XOR});
    model_lmmv(9'd101, 10'd300, 4, 3, 8'ha6, {1'b0, LOP_XOR});
    compare_all("lmmv xor");
    // Color masks to zero, transparent leaves all dots
    write_reg(REG_CLR, 8'hf0);
    run_command({CMD_LMMV, 1'b1, LOP_IMP});
    model_lmmv(9'd101, 10'd300, 4, 3, 8'hf0, {1'b1, LOP_IMP});
    compare_all("lmmv transparent");
  endtask

  task automatic test_hmmv_g7();
    logic [9:0] y;
    logic [8:0] x;
    set_mode(1'b1);
    fill_memory();
    set_rect(9'd250, 10'd20, 10'd10, 10'd3, 8'h00);
    write_reg(REG_CLR, 8'h3c);
    run_command({CMD_HMMV, 4'h0});
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 10; c++) begin
        y = 10'(20 + r);
        x = 9'(250 + c);
        // Row stops at X 255
        if (x < 9'd256) begin
          ref_mem[{y[8:0], x[7:0]}] = 8'h3c;
        end
      end
    end
    compare_all("hmmv across x 256");
  endtask

  task automatic test_point();
    vram_byte_u b;
    fill_memory();
    set_mode(1'b1);
    set_point(9'd77, 10'd140);
    run_command({CMD_POINT, 4'h0});
    check_byte("point g7", ref_mem[{9'd140, 8'd77}], clr);
    set_mode(1'b0);
    // Odd X, low nibble
    set_point(9'd45, 10'd700);
    run_command({CMD_POINT, 4'h0});
    b = ref_mem[{10'd700, 7'd22}];
    check_byte("point g4 odd", {4'h0, b.nib.lo}, clr);
    // Even X, high nibble
    set_point(9'd46, 10'd701);
    run_command({CMD_POINT, 4'h0});
    b = ref_mem[{10'd701, 7'd23}];
    check_byte("point g4 even", {4'h0, b.nib.hi}, clr);
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    reg_wr_req     = 1'b0;
    reg_num        = 4'h0;
    reg_data       = 8'h00;
    mode_graphic_7 = 1'b0;
    vram_rd_ack    = 1'b0;
    vram_wr_ack    = 1'b0;
    vram_rd_data   = 8'h00;
    rd_cnt         = 3'd0;
    wr_cnt         = 3'd0;
    lfsr           = 17'd92912;
    fill_memory();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_registers();
    test_pset_g7();
    test_lmmv_g4();
    test_hmmv_g7();
    test_point();
    @(negedge clk);
    if (dut.props.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "handshake assertions failed");
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/vdp_cmd_pkg.sv
verilog/vdp_cmd_pixel_unit.sv
verilog/vdp_cmd_regs.sv
verilog/vdp_cmd_sequencer.sv
verilog/vdp_cmd_engine.sv
sim/vdp_cmd_props.sv
sim/vdp_cmd_tb.sv

// ==== Bender.yml ====
package:
  name: vdp_cmd

sources:
  - verilog/vdp_cmd_pkg.sv
  - verilog/vdp_cmd_pixel_unit.sv
  - verilog/vdp_cmd_regs.sv
  - verilog/vdp_cmd_sequencer.sv
  - verilog/vdp_cmd_engine.sv
  - target: simulation
    files:
      - sim/vdp_cmd_props.sv
      - sim/vdp_cmd_tb.sv
